//--- rtl/vram_macros.svh
`ifndef VRAM_MACROS_SVH
`define VRAM_MACROS_SVH

// VRAM geometry
`define VRAM_ADDR_W 13
`define VRAM_DATA_W 8

// CPU bus
`define AXIL_ADDR_W 16
`define AXIL_DATA_W 32
`define AXI_RESP_OKAY 2'b00
`define AXI_RESP_SLVERR 2'b10

// VRAM fills the address map below the control register
`define DMA_CTRL_ADDR 16'h2000
`define DMA_PAGE_W 5

// OAM copy
`define OAM_BYTES 160
`define OAM_IDX_W 7
`define LOCKED_READ_DATA 8'hFF

`endif

//--- rtl/vram_pkg.sv
`include "vram_macros.svh"

package vram_pkg;

	typedef struct packed {
		logic                    awvalid;
		logic [`AXIL_ADDR_W-1:0] awaddr;
		logic                    wvalid;
		logic [`AXIL_DATA_W-1:0] wdata;
		logic [3:0]              wstrb;
		logic                    bready;
		logic                    arvalid;
		logic [`AXIL_ADDR_W-1:0] araddr;
		logic                    rready;
	} axil_m2s_t;

	typedef struct packed {
		logic                    awready;
		logic                    wready;
		logic                    bvalid;
		logic [1:0]              bresp;
		logic                    arready;
		logic                    rvalid;
		logic [`AXIL_DATA_W-1:0] rdata;
		logic [1:0]              rresp;
	} axil_s2m_t;

	typedef struct packed {
		logic                    valid;
		logic                    we;
		logic [`VRAM_ADDR_W-1:0] addr;
		logic [`VRAM_DATA_W-1:0] wdata;
	} vram_req_t;

	typedef struct packed {
		logic                    done;
		logic [`VRAM_DATA_W-1:0] rdata;
	} vram_rsp_t;

	typedef struct packed {
		logic                    req;
		logic [`VRAM_ADDR_W-1:0] addr;
	} fetch_req_t;

	// Bank 0 takes the even bytes, bank 1 the odd ones
	typedef struct packed {
		logic                    valid;
		logic                    bank;
		logic [`OAM_IDX_W-1:0]   index;
		logic [`VRAM_DATA_W-1:0] data;
	} oam_wr_t;

	typedef enum logic [1:0] {
		SRC_NONE  = 2'd0,
		SRC_FETCH = 2'd1,
		SRC_DMA   = 2'd2,
		SRC_CPU   = 2'd3
	} vram_src_e;

endpackage

//--- rtl/vram_array.sv
`timescale 1ns/100ps
`default_nettype none
`include "vram_macros.svh"

module vram_array (
	input  logic                    phi,
	input  logic [`VRAM_ADDR_W-1:0] addr,
	input  logic                    we,
	input  logic [`VRAM_DATA_W-1:0] wdata,
	output logic [`VRAM_DATA_W-1:0] rdata
);

	localparam int DEPTH = 1 << `VRAM_ADDR_W;

	logic [`VRAM_DATA_W-1:0] mem [DEPTH];

	// A write shows its own data on the read port in the next cycle
	always_ff @(posedge phi) begin
		if (we) begin
			mem[addr] <= wdata;
			rdata <= wdata;
		end else begin
			rdata <= mem[addr];
		end
	end

endmodule

`default_nettype wire

//--- rtl/vram_interface.sv
`timescale 1ns/100ps
`default_nettype none
`include "vram_macros.svh"

module vram_interface (
	input  logic                    phi,
	input  logic                    rst_n,

	input  vram_pkg::fetch_req_t    fetch,
	output logic [`VRAM_DATA_W-1:0] fetch_data,
	output logic                    fetch_valid,

	input  logic                    rendering,

	input  vram_pkg::vram_req_t     dma_req,
	output logic                    dma_grant,

	input  vram_pkg::vram_req_t     cpu_req,
	output vram_pkg::vram_rsp_t     cpu_rsp,

	output logic [`VRAM_ADDR_W-1:0] ram_addr,
	output logic                    ram_we,
	output logic [`VRAM_DATA_W-1:0] ram_wdata,
	input  logic [`VRAM_DATA_W-1:0] ram_rdata
);

	vram_pkg::vram_src_e src;
	vram_pkg::vram_src_e owner_q;
	logic                locked_q;
	logic                cpu_inflight;

	// ################################################
	// Grant

	// The port keeps its request up through the done cycle
	assign cpu_inflight = (owner_q == vram_pkg::SRC_CPU);

	always_comb begin
		src = vram_pkg::SRC_NONE;
		if (fetch.req)
			src = vram_pkg::SRC_FETCH;
		else if (dma_req.valid && !rendering)
			src = vram_pkg::SRC_DMA;
		else if (cpu_req.valid && !cpu_inflight)
			src = vram_pkg::SRC_CPU;
	end

	assign dma_grant = (src == vram_pkg::SRC_DMA);

	// ################################################
	// Array steering

	always_comb begin
		case (src)
			vram_pkg::SRC_FETCH: ram_addr = fetch.addr;
			vram_pkg::SRC_DMA:   ram_addr = dma_req.addr;
			default:             ram_addr = cpu_req.addr;
		endcase
	end

	// A locked CPU write never reaches the array
	assign ram_we    = (src == vram_pkg::SRC_CPU) && cpu_req.we && !rendering;
	assign ram_wdata = cpu_req.wdata;

	// ################################################
	// Read data return

	always_ff @(posedge phi or negedge rst_n) begin
		if (!rst_n) begin
			owner_q  <= vram_pkg::SRC_NONE;
			locked_q <= 1'b0;
		end else begin
			owner_q  <= src;
			locked_q <= (src == vram_pkg::SRC_CPU) && rendering;
		end
	end

	assign fetch_valid = (owner_q == vram_pkg::SRC_FETCH);
	assign fetch_data  = ram_rdata;

	always_comb begin
		cpu_rsp.done  = cpu_inflight;
		cpu_rsp.rdata = locked_q ? `LOCKED_READ_DATA : ram_rdata;
	end

	// A finished CPU access was granted in a cycle without fetch traffic
	a_cpu_behind_fetch: assert property (@(posedge phi) disable iff (!rst_n)
		cpu_rsp.done |-> $past(!fetch.req));

	a_no_write_rendering: assert property (@(posedge phi) disable iff (!rst_n)
		ram_we |-> !rendering);

endmodule

`default_nettype wire

//--- rtl/cpu_vram_port.sv
`timescale 1ns/100ps
`default_nettype none
`include "vram_macros.svh"

module cpu_vram_port (
	input  logic                   phi,
	input  logic                   rst_n,
	input  vram_pkg::axil_m2s_t    axil_m2s,
	output vram_pkg::axil_s2m_t    axil_s2m,
	output vram_pkg::vram_req_t    cpu_req,
	input  vram_pkg::vram_rsp_t    cpu_rsp,
	output logic                   dma_start,
	output logic [`DMA_PAGE_W-1:0] dma_page,
	input  logic                   dma_active
);

	logic                    awready_q, arready_q;
	logic                    bvalid_q, rvalid_q;
	logic [1:0]              bresp_q, rresp_q;
	logic [`AXIL_DATA_W-1:0] rdata_q;
	logic                    w_pend, r_pend;
	logic [`VRAM_ADDR_W-1:0] w_addr, r_addr;
	logic [`VRAM_DATA_W-1:0] w_data;
	logic                    hold_q, hold_wr_q, sel_wr;
	logic                    aw_hs, ar_hs;
	logic                    aw_vram, aw_ctrl, ar_vram, ar_ctrl;
	logic                    w_local, dma_go;

	assign aw_hs = awready_q && axil_m2s.awvalid && axil_m2s.wvalid;
	assign ar_hs = arready_q && axil_m2s.arvalid;

	assign aw_vram = (axil_m2s.awaddr < `DMA_CTRL_ADDR);
	assign aw_ctrl = (axil_m2s.awaddr == `DMA_CTRL_ADDR);
	assign ar_vram = (axil_m2s.araddr < `DMA_CTRL_ADDR);
	assign ar_ctrl = (axil_m2s.araddr == `DMA_CTRL_ADDR);

	// Writes answered straight away, without going through the VRAM slot
	assign w_local = !(aw_vram && axil_m2s.wstrb[0]);
	assign dma_go  = aw_hs && aw_ctrl && axil_m2s.wstrb[0] && !dma_active;

	// Once presented, the slot keeps its choice until done
	assign sel_wr = hold_q ? hold_wr_q : w_pend;

	always_comb begin
		cpu_req.valid = w_pend || r_pend;
		cpu_req.we    = sel_wr;
		cpu_req.addr  = sel_wr ? w_addr : r_addr;
		cpu_req.wdata = w_data;
	end

	// ################################################
	// Control

	always_ff @(posedge phi or negedge rst_n) begin
		if (!rst_n) begin
			awready_q <= 1'b0;
			arready_q <= 1'b0;
			bvalid_q  <= 1'b0;
			rvalid_q  <= 1'b0;
			w_pend    <= 1'b0;
			r_pend    <= 1'b0;
			hold_q    <= 1'b0;
			hold_wr_q <= 1'b0;
			dma_start <= 1'b0;
		end else begin
			awready_q <= axil_m2s.awvalid && axil_m2s.wvalid && !awready_q &&
				!w_pend && !bvalid_q;
			arready_q <= axil_m2s.arvalid && !arready_q && !r_pend && !rvalid_q;
			dma_start <= dma_go;

			if (bvalid_q && axil_m2s.bready)
				bvalid_q <= 1'b0;
			if (rvalid_q && axil_m2s.rready)
				rvalid_q <= 1'b0;

			if (aw_hs) begin
				if (w_local)
					bvalid_q <= 1'b1;
				else
					w_pend <= 1'b1;
			end
			if (ar_hs) begin
				if (ar_vram)
					r_pend <= 1'b1;
				else
					rvalid_q <= 1'b1;
			end

			if (cpu_rsp.done) begin
				hold_q <= 1'b0;
				if (sel_wr) begin
					w_pend   <= 1'b0;
					bvalid_q <= 1'b1;
				end else begin
					r_pend   <= 1'b0;
					rvalid_q <= 1'b1;
				end
			end else if (cpu_req.valid) begin
				hold_q    <= 1'b1;
				hold_wr_q <= sel_wr;
			end
		end
	end

	// ################################################
	// Payload

	always_ff @(posedge phi) begin
		if (aw_hs) begin
			w_addr  <= axil_m2s.awaddr[`VRAM_ADDR_W-1:0];
			w_data  <= axil_m2s.wdata[`VRAM_DATA_W-1:0];
			bresp_q <= (aw_vram || aw_ctrl) ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR;
		end
		if (dma_go)
			dma_page <= axil_m2s.wdata[`DMA_PAGE_W-1:0];

		if (ar_hs) begin
			r_addr  <= axil_m2s.araddr[`VRAM_ADDR_W-1:0];
			rresp_q <= (ar_vram || ar_ctrl) ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR;
			rdata_q <= ar_ctrl ? {{(`AXIL_DATA_W-1){1'b0}}, dma_active} : '0;
		end

		if (cpu_rsp.done && !sel_wr)
			rdata_q <= {{(`AXIL_DATA_W-`VRAM_DATA_W){1'b0}}, cpu_rsp.rdata};
	end

	always_comb begin
		axil_s2m.awready = awready_q;
		axil_s2m.wready  = awready_q;
		axil_s2m.bvalid  = bvalid_q;
		axil_s2m.bresp   = bresp_q;
		axil_s2m.arready = arready_q;
		axil_s2m.rvalid  = rvalid_q;
		axil_s2m.rdata   = rdata_q;
		axil_s2m.rresp   = rresp_q;
	end

	a_bvalid_hold: assert property (@(posedge phi) disable iff (!rst_n)
		axil_s2m.bvalid && !axil_m2s.bready |=> axil_s2m.bvalid && $stable(axil_s2m.bresp));

endmodule

`default_nettype wire

//--- rtl/oam_dma_engine.sv
`timescale 1ns/100ps
`default_nettype none
`include "vram_macros.svh"

module oam_dma_engine (
	input  logic                    phi,
	input  logic                    rst_n,
	input  logic                    dma_start,
	input  logic [`DMA_PAGE_W-1:0]  dma_page,
	output vram_pkg::vram_req_t     dma_req,
	input  logic                    dma_grant,
	input  logic [`VRAM_DATA_W-1:0] ram_rdata,
	output logic                    dma_active,
	output vram_pkg::oam_wr_t       oam_wr
);

	localparam logic [`OAM_IDX_W:0] LAST = (`OAM_IDX_W+1)'(`OAM_BYTES - 1);

	logic                   active_q, issue_q, rd_q;
	logic [`OAM_IDX_W:0]    cnt, rd_idx;
	logic [`DMA_PAGE_W-1:0] page_q;
	logic                   last_write;

	assign last_write = rd_q && (rd_idx == LAST);

	always_ff @(posedge phi or negedge rst_n) begin
		if (!rst_n) begin
			active_q <= 1'b0;
			issue_q  <= 1'b0;
			rd_q     <= 1'b0;
			cnt      <= '0;
		end else begin
			rd_q <= dma_grant;
			if (dma_start) begin
				active_q <= 1'b1;
				issue_q  <= 1'b1;
				cnt      <= '0;
			end else begin
				if (dma_grant) begin
					if (cnt == LAST)
						issue_q <= 1'b0;
					else
						cnt <= cnt + 1'b1;
				end
				// Busy drops only once the final byte has gone out to OAM
				if (last_write)
					active_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge phi) begin
		if (dma_start)
			page_q <= dma_page;
		if (dma_grant)
			rd_idx <= cnt;
	end

	always_comb begin
		dma_req.valid = issue_q;
		dma_req.we    = 1'b0;
		dma_req.addr  = {page_q, cnt};
		dma_req.wdata = '0;
	end

	assign dma_active = active_q;

	always_comb begin
		oam_wr.valid = rd_q;
		oam_wr.bank  = rd_idx[0];
		oam_wr.index = rd_idx[`OAM_IDX_W:1];
		oam_wr.data  = ram_rdata;
	end

	a_cnt_range: assert property (@(posedge phi) disable iff (!rst_n)
		cnt <= LAST);

endmodule

`default_nettype wire

//--- rtl/vram_subsystem.sv
`timescale 1ns/100ps
`default_nettype none
`include "vram_macros.svh"

module vram_subsystem (
	input  logic                    phi,
	input  logic                    rst_n,
	input  vram_pkg::axil_m2s_t     axil_m2s,
	output vram_pkg::axil_s2m_t     axil_s2m,
	input  vram_pkg::fetch_req_t    fetch,
	output logic [`VRAM_DATA_W-1:0] fetch_data,
	output logic                    fetch_valid,
	input  logic                    rendering,
	output vram_pkg::oam_wr_t       oam_wr
);

	vram_pkg::vram_req_t     cpu_req, dma_req;
	vram_pkg::vram_rsp_t     cpu_rsp;
	logic                    dma_start, dma_active, dma_grant;
	logic [`DMA_PAGE_W-1:0]  dma_page;
	logic [`VRAM_ADDR_W-1:0] ram_addr;
	logic                    ram_we;
	logic [`VRAM_DATA_W-1:0] ram_wdata, ram_rdata;

	cpu_vram_port u_port (
		.phi(phi), .rst_n(rst_n),
		.axil_m2s(axil_m2s), .axil_s2m(axil_s2m),
		.cpu_req(cpu_req), .cpu_rsp(cpu_rsp),
		.dma_start(dma_start), .dma_page(dma_page), .dma_active(dma_active)
	);

	oam_dma_engine u_dma (
		.phi(phi), .rst_n(rst_n),
		.dma_start(dma_start), .dma_page(dma_page),
		.dma_req(dma_req), .dma_grant(dma_grant), .ram_rdata(ram_rdata),
		.dma_active(dma_active), .oam_wr(oam_wr)
	);

	vram_interface u_vif (
		.phi(phi), .rst_n(rst_n),
		.fetch(fetch), .fetch_data(fetch_data), .fetch_valid(fetch_valid),
		.rendering(rendering),
		.dma_req(dma_req), .dma_grant(dma_grant),
		.cpu_req(cpu_req), .cpu_rsp(cpu_rsp),
		.ram_addr(ram_addr), .ram_we(ram_we), .ram_wdata(ram_wdata), .ram_rdata(ram_rdata)
	);

	vram_array u_ram (
		.phi(phi), .addr(ram_addr), .we(ram_we), .wdata(ram_wdata), .rdata(ram_rdata)
	);

endmodule

`default_nettype wire

//--- test/tb_vram_subsystem.sv
`timescale 1ns/100ps
`include "vram_macros.svh"

module tb_vram_subsystem;

	localparam int VRAM_BYTES = 1 << `VRAM_ADDR_W;
	// Roughly 330 bus operations at up to ten cycles each, plus DMA and fetch phases
	localparam int TIMEOUT_CYCLES = 5000;

	logic                    phi;
	logic                    rst_n;
	vram_pkg::axil_m2s_t     m2s;
	vram_pkg::axil_s2m_t     s2m;
	vram_pkg::fetch_req_t    fetch;
	logic [`VRAM_DATA_W-1:0] fetch_data;
	logic                    fetch_valid;
	logic                    rendering;
	vram_pkg::oam_wr_t       oam_wr;

	logic [`VRAM_DATA_W-1:0] ref_mem [VRAM_BYTES];
	logic [`VRAM_ADDR_W-1:0] known [$];
	vram_pkg::oam_wr_t       oam_seen [$];
	logic                    fetch_was;
	logic [`VRAM_ADDR_W-1:0] fetch_was_addr;
	int                      cycle = 0;
	int                      mon_errors = 0;
	int                      errors;
	int                      test_base;
	int                      pass_cnt;
	int                      fail_cnt;
	int                      read_done_cycle;
	string                   test_name;

	vram_subsystem DUT (
		.phi(phi), .rst_n(rst_n),
		.axil_m2s(m2s), .axil_s2m(s2m),
		.fetch(fetch), .fetch_data(fetch_data), .fetch_valid(fetch_valid),
		.rendering(rendering), .oam_wr(oam_wr)
	);

	initial phi = 1'b0;
	always #4 phi = ~phi;

	// ##################################################
	// Reference model and checks

	function automatic logic [`VRAM_DATA_W-1:0] expected_read(
		input logic [`VRAM_ADDR_W-1:0] addr, input logic locked);
		if (locked)
			return `LOCKED_READ_DATA;
		return ref_mem[addr];
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual, ref int failures);
		if (actual !== expected) begin
			$display("mismatch %s %s expected %0h actual %0h", test_name, what, expected, actual);
			failures++;
		end
	endtask

	task automatic report_failure(input string what, ref int failures);
		$display("error in %s: %s", test_name, what);
		failures++;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_base = errors + mon_errors;
	endtask

	task automatic finish_test();
		if (errors + mon_errors == test_base) begin
			$display("test %s passed", test_name);
			pass_cnt++;
		end else begin
			$display("test %s failed", test_name);
			fail_cnt++;
		end
	endtask

	function automatic logic [`VRAM_ADDR_W-1:0] pick_known();
		return known[$urandom_range(known.size() - 1)];
	endfunction

	// Fetch results and OAM writes are checked or collected every cycle
	always @(posedge phi) begin
		cycle <= cycle + 1;
		fetch_was <= fetch.req;
		fetch_was_addr <= fetch.addr;
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	always @(negedge phi) begin
		if (rst_n) begin
			if (fetch_valid !== fetch_was)
				report_failure("fetch_valid did not follow the fetch request", mon_errors);
			else if (fetch_was)
				check_value("fetch_data", 32'(expected_read(fetch_was_addr, 1'b0)),
					32'(fetch_data), mon_errors);
			if (oam_wr.valid)
				oam_seen.push_back(oam_wr);
		end
	end

	// ##################################################
	// AXI4-Lite bus tasks

	task automatic axil_write(input logic [15:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		m2s.awvalid = 1'b1;
		m2s.awaddr  = addr;
		m2s.wvalid  = 1'b1;
		m2s.wdata   = data;
		do @(negedge phi); while (!s2m.awready);
		check_value("wready", 32'd1, 32'(s2m.wready), errors);
		@(posedge phi);
		#1;
		m2s.awvalid = 1'b0;
		m2s.wvalid  = 1'b0;
		do @(negedge phi); while (!s2m.bvalid);
		resp = s2m.bresp;
		@(posedge phi);
		#1;
	endtask

	task automatic axil_read(input logic [15:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		m2s.arvalid = 1'b1;
		m2s.araddr  = addr;
		do @(negedge phi); while (!s2m.arready);
		@(posedge phi);
		#1;
		m2s.arvalid = 1'b0;
		do @(negedge phi); while (!s2m.rvalid);
		data = s2m.rdata;
		resp = s2m.rresp;
		read_done_cycle = cycle;
		@(posedge phi);
		#1;
	endtask

	// ##################################################
	// Tests

	task automatic test_write_read();
		logic [`VRAM_ADDR_W-1:0] addrs [64];
		logic [`VRAM_DATA_W-1:0] d;
		logic [31:0]             rd;
		logic [1:0]              resp;
		start_test("cpu_write_read");
		for (int i = 0; i < 64; i++) begin
			addrs[i] = `VRAM_ADDR_W'($urandom());
			d = `VRAM_DATA_W'($urandom());
			axil_write(16'(addrs[i]), 32'(d), resp);
			check_value("bresp", 32'(`AXI_RESP_OKAY), 32'(resp), errors);
			ref_mem[addrs[i]] = d;
			known.push_back(addrs[i]);
		end
		for (int i = 0; i < 64; i++) begin
			axil_read(16'(addrs[i]), rd, resp);
			check_value("rdata", 32'(expected_read(addrs[i], 1'b0)), 32'(rd[7:0]), errors);
			check_value("rresp", 32'(`AXI_RESP_OKAY), 32'(resp), errors);
		end
		finish_test();
	endtask

	task automatic test_lockout();
		logic [`VRAM_ADDR_W-1:0] addrs [8];
		logic [31:0]             rd;
		logic [1:0]              resp;
		start_test("lockout");
		rendering = 1'b1;
		for (int i = 0; i < 8; i++) begin
			addrs[i] = pick_known();
			axil_read(16'(addrs[i]), rd, resp);
			check_value("locked rdata", 32'(expected_read(addrs[i], 1'b1)), 32'(rd[7:0]),
				errors);
			check_value("locked rresp", 32'(`AXI_RESP_OKAY), 32'(resp), errors);
			// The write is dropped, so the model keeps its value
			axil_write(16'(addrs[i]), 32'(~ref_mem[addrs[i]]), resp);
			check_value("locked bresp", 32'(`AXI_RESP_OKAY), 32'(resp), errors);
		end
		rendering = 1'b0;
		for (int i = 0; i < 8; i++) begin
			axil_read(16'(addrs[i]), rd, resp);
			check_value("rdata after lockout", 32'(expected_read(addrs[i], 1'b0)),
				32'(rd[7:0]), errors);
		end
		finish_test();
	endtask

	task automatic test_fetch();
		start_test("fetch");
		for (int i = 0; i < 32; i++) begin
			fetch.req  = 1'b1;
			fetch.addr = pick_known();
			rendering  = (i >= 12 && i < 20);
			@(posedge phi);
			#1;
			if (i % 5 == 4) begin
				fetch.req = 1'b0;
				@(posedge phi);
				#1;
			end
		end
		fetch.req = 1'b0;
		rendering = 1'b0;
		repeat (2) @(posedge phi);
		#1;
		finish_test();
	endtask

	task automatic test_dma();
		logic [`DMA_PAGE_W-1:0]  page;
		logic [`VRAM_ADDR_W-1:0] a;
		logic [`VRAM_DATA_W-1:0] d;
		logic [31:0]             rd;
		logic [1:0]              resp;
		int                      base;
		int                      polls;
		int                      offset;
		bit                      seen [`OAM_BYTES];
		vram_pkg::oam_wr_t       w;
		start_test("oam_dma");
		page = `DMA_PAGE_W'($urandom());
		for (int i = 0; i < `OAM_BYTES; i++) begin
			a = {page, 8'(i)};
			d = `VRAM_DATA_W'($urandom());
			axil_write(16'(a), 32'(d), resp);
			ref_mem[a] = d;
			seen[i] = 1'b0;
		end
		base = oam_seen.size();
		axil_write(`DMA_CTRL_ADDR, 32'(page), resp);
		check_value("dma start bresp", 32'(`AXI_RESP_OKAY), 32'(resp), errors);
		axil_read(`DMA_CTRL_ADDR, rd, resp);
		check_value("dma busy", 32'd1, 32'(rd[0]), errors);
		polls = 0;
		do begin
			axil_read(`DMA_CTRL_ADDR, rd, resp);
			polls++;
		end while (rd[0] && polls < 400);
		if (rd[0])
			report_failure("DMA stayed busy and never finished", errors);
		check_value("oam write count", 32'(`OAM_BYTES), 32'(oam_seen.size() - base), errors);
		for (int i = base; i < oam_seen.size(); i++) begin
			w = oam_seen[i];
			offset = int'(w.index) * 2 + int'(w.bank);
			if (offset >= `OAM_BYTES || seen[offset]) begin
				report_failure("OAM write hit an offset out of range or twice", errors);
			end else begin
				seen[offset] = 1'b1;
				check_value("oam data", 32'(expected_read({page, 8'(offset)}, 1'b0)),
					32'(w.data), errors);
			end
		end
		finish_test();
	endtask

	task automatic test_errors();
		logic [`VRAM_ADDR_W-1:0] a;
		logic [15:0]             ea;
		logic [31:0]             rd;
		logic [1:0]              resp;
		start_test("error_response");
		for (int i = 0; i < 8; i++) begin
			a = pick_known();
			// Low bits alias a live VRAM byte, which has to stay untouched
			ea = (i == 0) ? 16'h2001 : (16'h4000 | 16'(a));
			axil_write(ea, 32'(~ref_mem[a]), resp);
			check_value("error bresp", 32'(`AXI_RESP_SLVERR), 32'(resp), errors);
			axil_read(ea, rd, resp);
			check_value("error rresp", 32'(`AXI_RESP_SLVERR), 32'(resp), errors);
			check_value("error rdata", 32'd0, rd, errors);
			axil_read(16'(a), rd, resp);
			check_value("rdata after error", 32'(expected_read(a, 1'b0)), 32'(rd[7:0]), errors);
		end
		finish_test();
	endtask

	task automatic test_contention();
		logic [`VRAM_ADDR_W-1:0] a;
		logic [31:0]             rd;
		logic [1:0]              resp;
		int                      fetch_end;
		start_test("contention");
		a = pick_known();
		fork
			axil_read(16'(a), rd, resp);
			begin
				for (int i = 0; i < 20; i++) begin
					fetch.req  = 1'b1;
					fetch.addr = pick_known();
					@(posedge phi);
					#1;
				end
				fetch.req = 1'b0;
				fetch_end = cycle;
			end
		join
		if (read_done_cycle <= fetch_end)
			report_failure("CPU read finished while fetch requests were still active", errors);
		check_value("rdata", 32'(expected_read(a, 1'b0)), 32'(rd[7:0]), errors);
		check_value("rresp", 32'(`AXI_RESP_OKAY), 32'(resp), errors);
		repeat (2) @(posedge phi);
		#1;
		finish_test();
	endtask

	// ##################################################
	// Sequence

	initial begin
		void'($urandom(30));
		m2s        = '0;
		m2s.wstrb  = 4'hF;
		m2s.bready = 1'b1;
		m2s.rready = 1'b1;
		fetch      = '0;
		rendering  = 1'b0;
		rst_n      = 1'b0;
		errors     = 0;
		pass_cnt   = 0;
		fail_cnt   = 0;
		test_name  = "reset";
		repeat (2) @(posedge phi);
		#1;
		rst_n = 1'b1;

		test_write_read();
		test_lockout();
		test_fetch();
		test_dma();
		test_errors();
		test_contention();

		$display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && errors + mon_errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- vram_sys.f
+incdir+rtl
rtl/vram_pkg.sv
rtl/vram_array.sv
rtl/vram_interface.sv
rtl/cpu_vram_port.sv
rtl/oam_dma_engine.sv
rtl/vram_subsystem.sv
test/tb_vram_subsystem.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_vram_subsystem -Mdir obj_dir -f vram_sys.f

output=$(./obj_dir/Vtb_vram_subsystem)
echo "$output"

if grep -q "ALL TESTS PASSED" <<< "$output"; then
	exit 0
fi
exit 1
